// File: design/addr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_subsys_defines.svh"

module addr_decoder (
    input  wire logic [`WORD_WIDTH-1:0] addr,
    output mem_subsys_pkg::addr_info_t  info
);
    import mem_subsys_pkg::*;

    logic [`WORD_WIDTH-1:0] led_offset;

    assign led_offset = addr - `LED_FIRST;

    always_comb begin
        info = '0;
        if (addr <= `DRAM_LAST) begin
            info.region = REGION_DRAM;
        end else if (addr >= `LED_FIRST && addr <= `LED_LAST) begin
            info.region = REGION_LED;
        end else begin
            info.region = REGION_UNMAPPED;
        end

        // Only DRAM addresses reach the controller. Everything else reads word 0.
        if (info.region == REGION_DRAM) begin
            info.dram_addr = {{(`DRAM_ADDR_WIDTH - `WORD_WIDTH){1'b0}}, addr};
        end

        if (info.region == REGION_LED) begin
            info.led_idx = led_offset[$bits(led_idx_t)-1:0];
        end
    end

endmodule

`default_nettype wire

// File: design/dram_ctl.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_subsys_defines.svh"

module dram_ctl (
    input  wire logic                       clk,
    input  wire logic                       rst,
    input  wire mem_subsys_pkg::dram_req_t  dram_req,
    output mem_subsys_pkg::dram_rsp_t       dram_rsp
);
    import mem_subsys_pkg::*;

    localparam int IDX_WIDTH   = $clog2(`DRAM_MODEL_WORDS);
    localparam int COUNT_WIDTH = $clog2(`DRAM_LATENCY + 1);

    // Storage starts out all zero.
    logic [`WORD_WIDTH-1:0] mem [`DRAM_MODEL_WORDS] = '{default: '0};

    logic [IDX_WIDTH-1:0]   idx_q;
    logic                   write_en_q;
    logic [`WORD_WIDTH-1:0] wdata_q;
    logic [COUNT_WIDTH-1:0] count;
    logic                   expire;
    logic                   ready_q;
    logic [`WORD_WIDTH-1:0] rdata_q;

    // The response is registered on the edge that ends the last wait cycle.
    assign expire = (count == COUNT_WIDTH'(1));

    // Request latch.
    always_ff @(posedge clk) begin
        if (dram_req.strobe) begin
            idx_q      <= dram_req.addr[IDX_WIDTH-1:0];
            write_en_q <= dram_req.write_en;
            wdata_q    <= dram_req.wdata;
        end
    end

    // The strobe cycle counts as the first cycle of the latency.
    // Needs DRAM_LATENCY of at least 2.
    always_ff @(posedge clk) begin
        if (!rst) begin
            count   <= '0;
            ready_q <= 1'b0;
        end else begin
            ready_q <= expire;
            if (dram_req.strobe) begin
                count <= COUNT_WIDTH'(`DRAM_LATENCY - 1);
            end else if (count != '0) begin
                count <= count - 1'b1;
            end
        end
    end

    // Read first, so a write hands back the old word.
    always_ff @(posedge clk) begin
        if (expire) begin
            rdata_q <= mem[idx_q];
            if (write_en_q) begin
                mem[idx_q] <= wdata_q;
            end
        end
    end

    always_comb begin
        dram_rsp.ready = ready_q;
        dram_rsp.rdata = rdata_q;
    end

endmodule

`default_nettype wire

// File: design/mem_map.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_subsys_defines.svh"

module mem_map (
    input  wire logic                        clk,
    input  wire logic                        rst,
    input  wire logic                        cpu_ready,
    input  wire mem_subsys_pkg::cpu_port_t   cpu,
    input  wire mem_subsys_pkg::addr_info_t  pc_info,
    input  wire mem_subsys_pkg::addr_info_t  data_info,
    input  wire mem_subsys_pkg::dram_rsp_t   dram_rsp,
    output mem_subsys_pkg::dram_req_t        dram_req,
    output logic [`WORD_WIDTH-1:0]           instr,
    output logic [`WORD_WIDTH-1:0]           read_data,
    output logic [`LED_COUNT-1:0]            led,
    output logic                             busy
);
    import mem_subsys_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_FETCH_INSTR,
        ST_WAIT,
        ST_INSTR_OUT,
        ST_FETCH_DATA,
        ST_DATA_OUT
    } state_e;

    state_e                      state;
    state_e                      next_state;
    logic                        got_instr;
    logic [`WORD_WIDTH-1:0]      last_pc;
    logic                        start;
    logic                        issue_fetch;
    logic                        issue_data;
    logic                        led_write;
    logic                        strobe_q;
    logic [`DRAM_ADDR_WIDTH-1:0] addr_q;
    logic                        write_en_q;
    logic [`WORD_WIDTH-1:0]      wdata_q;

    // A new access cycle needs a pc we have not served yet.
    assign start = cpu_ready && (cpu.pc != last_pc);

    assign issue_fetch = (state == ST_IDLE) && start;
    assign issue_data  = (state == ST_INSTR_OUT);
    assign led_write   = cpu.write_en && (data_info.region == REGION_LED);

    assign busy = (state != ST_IDLE) && (state != ST_DATA_OUT);

    always_comb begin
        next_state = state;
        case (state)
            ST_IDLE:
                if (start)
                    next_state = ST_FETCH_INSTR;
            ST_FETCH_INSTR:
                next_state = ST_WAIT;
            // The same wait state serves both accesses.
            ST_WAIT:
                if (dram_rsp.ready)
                    next_state = got_instr ? ST_DATA_OUT : ST_INSTR_OUT;
            ST_INSTR_OUT:
                next_state = ST_FETCH_DATA;
            ST_FETCH_DATA:
                next_state = ST_WAIT;
            ST_DATA_OUT:
                next_state = ST_IDLE;
            default:
                next_state = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state     <= ST_IDLE;
            got_instr <= 1'b0;
            last_pc   <= '1;
            strobe_q  <= 1'b0;
            instr     <= `NOP_INSTR;
            read_data <= '0;
            led       <= '0;
        end else begin
            state <= next_state;

            // One strobe cycle per DRAM request.
            strobe_q <= issue_fetch || issue_data;

            // all ones while the CPU is not ready, so any pc restarts
            if (!cpu_ready) begin
                last_pc <= '1;
            end else if (issue_fetch) begin
                last_pc <= cpu.pc;
            end

            if (issue_fetch) begin
                got_instr <= 1'b0;
            end

            if (state == ST_WAIT && dram_rsp.ready) begin
                if (got_instr) begin
                    read_data <= dram_rsp.rdata;
                end else begin
                    instr     <= dram_rsp.rdata;
                    got_instr <= 1'b1;
                end
            end

            // Visible in the data strobe cycle.
            if (issue_data && led_write) begin
                led[data_info.led_idx] <= cpu.data_in[0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue_fetch) begin
            addr_q     <= pc_info.dram_addr;
            write_en_q <= 1'b0;
            wdata_q    <= cpu.data_in;
        end else if (issue_data) begin
            addr_q     <= data_info.dram_addr;
            write_en_q <= cpu.write_en && (data_info.region == REGION_DRAM);
            wdata_q    <= cpu.data_in;
        end
    end

    always_comb begin
        dram_req.strobe   = strobe_q;
        dram_req.addr     = addr_q;
        dram_req.write_en = write_en_q;
        dram_req.wdata    = wdata_q;
    end

endmodule

`default_nettype wire

// File: design/mem_subsys.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_subsys_defines.svh"

module mem_subsys (
    input  wire logic                       clk,
    input  wire logic                       rst,
    input  wire logic                       cpu_ready,
    input  wire mem_subsys_pkg::cpu_port_t  cpu,
    output logic [`WORD_WIDTH-1:0]          instr,
    output logic [`WORD_WIDTH-1:0]          read_data,
    output logic [`LED_COUNT-1:0]           led,
    output logic                            busy
);
    import mem_subsys_pkg::*;

    addr_info_t pc_info;
    addr_info_t data_info;
    dram_req_t  dram_req;
    dram_rsp_t  dram_rsp;

    addr_decoder u_pc_decoder (
        .addr (cpu.pc),
        .info (pc_info)
    );

    addr_decoder u_data_decoder (
        .addr (cpu.data_addr),
        .info (data_info)
    );

    mem_map u_mem_map (
        .clk       (clk),
        .rst       (rst),
        .cpu_ready (cpu_ready),
        .cpu       (cpu),
        .pc_info   (pc_info),
        .data_info (data_info),
        .dram_rsp  (dram_rsp),
        .dram_req  (dram_req),
        .instr     (instr),
        .read_data (read_data),
        .led       (led),
        .busy      (busy)
    );

    dram_ctl u_dram_ctl (
        .clk      (clk),
        .rst      (rst),
        .dram_req (dram_req),
        .dram_rsp (dram_rsp)
    );

endmodule

`default_nettype wire

// File: design/mem_subsys_pkg.sv
`default_nettype none

`include "mem_subsys_defines.svh"

package mem_subsys_pkg;

    typedef enum logic [1:0] {
        REGION_DRAM,
        REGION_LED,
        REGION_UNMAPPED
    } region_e;

    typedef logic [$clog2(`LED_COUNT)-1:0] led_idx_t;

    typedef struct packed {
        region_e                     region;
        logic [`DRAM_ADDR_WIDTH-1:0] dram_addr;
        led_idx_t                    led_idx;
    } addr_info_t;

    typedef struct packed {
        logic [`WORD_WIDTH-1:0] pc;
        logic [`WORD_WIDTH-1:0] data_addr;
        logic [`WORD_WIDTH-1:0] data_in;
        logic                   write_en;
    } cpu_port_t;

    typedef struct packed {
        logic                        strobe;
        logic [`DRAM_ADDR_WIDTH-1:0] addr;
        logic                        write_en;
        logic [`WORD_WIDTH-1:0]      wdata;
    } dram_req_t;

    typedef struct packed {
        logic                   ready;
        logic [`WORD_WIDTH-1:0] rdata;
    } dram_rsp_t;

endpackage

`default_nettype wire

// File: include/mem_subsys_defines.svh
`ifndef MEM_SUBSYS_DEFINES_SVH
`define MEM_SUBSYS_DEFINES_SVH

// CPU word and address width.
`define WORD_WIDTH 16
`define DRAM_ADDR_WIDTH 25

// Address map bounds.
`define DRAM_LAST 16'hF7FF
`define LED_FIRST 16'hF800
`define LED_LAST 16'hF809
`define LED_COUNT 10

// Cycles from request strobe to ready pulse.
`define DRAM_LATENCY 4
`define DRAM_MODEL_WORDS 1024

// Instruction presented after reset, a nop.
`define NOP_INSTR 16'hF000

`endif

// File: mem_subsys.f
+incdir+include
design/mem_subsys_pkg.sv
design/addr_decoder.sv
design/mem_map.sv
design/dram_ctl.sv
design/mem_subsys.sv
verification/mem_subsys_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps \
    --top-module mem_subsys_tb --Mdir obj_dir \
    -f mem_subsys.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vmem_subsys_tb > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Checks failed" "$LOG"; then
    echo "Simulation reported a failure, see $LOG"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

echo "Simulation finished without errors"
exit 0

// File: verification/mem_subsys_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_subsys_defines.svh"

module mem_subsys_tb;
    import mem_subsys_pkg::*;

    localparam int DIRECTED_ACCESSES = 26;
    localparam int RANDOM_ACCESSES   = 60;
    localparam int TIMEOUT_CYCLES    = (DIRECTED_ACCESSES + RANDOM_ACCESSES) * 16 + 100;
    // Fetch strobe cycle through the read_data update.
    localparam int BUSY_CYCLES       = 2 * `DRAM_LATENCY + 3;
    localparam int IDX_W             = $clog2(`DRAM_MODEL_WORDS);

    typedef struct packed {
        logic [`WORD_WIDTH-1:0] instr;
        logic [`WORD_WIDTH-1:0] read_data;
        logic [`LED_COUNT-1:0]  led;
    } expect_t;

    logic                   clk;
    logic                   rst;
    logic                   cpu_ready;
    cpu_port_t              cpu;
    logic [`WORD_WIDTH-1:0] instr;
    logic [`WORD_WIDTH-1:0] read_data;
    logic [`LED_COUNT-1:0]  led;
    logic                   busy;

    logic [`WORD_WIDTH-1:0] shadow_mem [`DRAM_MODEL_WORDS];
    logic [`LED_COUNT-1:0]  shadow_led;
    expect_t                expected_q [$];
    integer                 seed;
    int                     cycle_count;
    int                     busy_cycles;
    logic                   busy_prev;

    mem_subsys DUT (
        .clk       (clk),
        .rst       (rst),
        .cpu_ready (cpu_ready),
        .cpu       (cpu),
        .instr     (instr),
        .read_data (read_data),
        .led       (led),
        .busy      (busy)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    task automatic report_failure(input string line);
        $display("%s", line);
        $display("Checks failed");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_word(input logic [`WORD_WIDTH-1:0] got,
                              input logic [`WORD_WIDTH-1:0] want, input string what);
        if (got !== want) begin
            report_failure($sformatf("** Error at time %0t: %s is %h, expected %h",
                                     $time, what, got, want));
        end
    endtask

    task automatic check_led(input logic [`LED_COUNT-1:0] got,
                             input logic [`LED_COUNT-1:0] want, input string what);
        if (got !== want) begin
            report_failure($sformatf("** Error at time %0t: %s is %b, expected %b",
                                     $time, what, got, want));
        end
    endtask

    task automatic check_flag(input logic got, input logic want, input string what);
        if (got !== want) begin
            report_failure($sformatf("** Error at time %0t: %s is %b, expected %b",
                                     $time, what, got, want));
        end
    endtask

    function automatic logic in_dram(input logic [`WORD_WIDTH-1:0] addr);
        return addr <= `DRAM_LAST;
    endfunction

    function automatic logic in_led(input logic [`WORD_WIDTH-1:0] addr);
        return addr >= `LED_FIRST && addr <= `LED_LAST;
    endfunction

    // Everything outside DRAM lands on word 0. DRAM aliases on the low bits.
    function automatic logic [IDX_W-1:0] shadow_index(input logic [`WORD_WIDTH-1:0] addr);
        if (in_dram(addr)) begin
            return addr[IDX_W-1:0];
        end
        return '0;
    endfunction

    // Instruction is fetched before the data access of the same cycle.
    function automatic expect_t mem_expect(input cpu_port_t acc);
        expect_t          e;
        logic [IDX_W-1:0] data_idx;
        logic [3:0]       led_idx;
        e.instr     = shadow_mem[shadow_index(acc.pc)];
        data_idx    = shadow_index(acc.data_addr);
        e.read_data = shadow_mem[data_idx];
        if (acc.write_en && in_dram(acc.data_addr)) begin
            shadow_mem[data_idx] = acc.data_in;
        end
        if (acc.write_en && in_led(acc.data_addr)) begin
            led_idx             = 4'(acc.data_addr - `LED_FIRST);
            shadow_led[led_idx] = acc.data_in[0];
        end
        e.led = shadow_led;
        return e;
    endfunction

    function automatic logic [`WORD_WIDTH-1:0] random_addr();
        logic [31:0]            r;
        int                     u;
        logic [`WORD_WIDTH-1:0] a;
        r = $random(seed);
        u = int'(r[30:8]);
        case (r[1:0])
            2'd0: a = 16'(u % (int'(`DRAM_LAST) + 1));
            // A small pool so that words get reused.
            2'd1: a = 16'(u % 16);
            2'd2: a = `LED_FIRST + 16'(u % `LED_COUNT);
            default: a = `LED_LAST + 16'd1 + 16'(u % (int'(16'hFFFE) - int'(`LED_LAST)));
        endcase
        return a;
    endfunction

    task automatic launch_access();
        expected_q.push_back(mem_expect(cpu));
        cpu_ready = 1'b1;
        do begin
            @(posedge clk);
            #1;
        end while (busy !== 1'b1);
        do begin
            @(posedge clk);
            #1;
        end while (busy !== 1'b0);
    endtask

    // Dropping cpu_ready for a cycle lets any pc start a new cycle.
    task automatic drive_access(input logic [`WORD_WIDTH-1:0] pc,
                                input logic [`WORD_WIDTH-1:0] data_addr,
                                input logic [`WORD_WIDTH-1:0] data_in, input logic write_en);
        cpu.pc        = pc;
        cpu.data_addr = data_addr;
        cpu.data_in   = data_in;
        cpu.write_en  = write_en;
        cpu_ready     = 1'b0;
        @(posedge clk);
        #1;
        launch_access();
    endtask

    task automatic hold_idle(input int cycles);
        logic [`WORD_WIDTH-1:0] instr_before;
        logic [`WORD_WIDTH-1:0] read_before;
        logic [`LED_COUNT-1:0]  led_before;
        instr_before = instr;
        read_before  = read_data;
        led_before   = led;
        repeat (cycles) begin
            @(posedge clk);
            #1;
            check_flag(busy, 1'b0, "busy while held");
            check_word(instr, instr_before, "instr while held");
            check_word(read_data, read_before, "read_data while held");
            check_led(led, led_before, "led while held");
        end
    endtask

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            report_failure($sformatf("Timeout: the run did not finish within %0d cycles",
                                     TIMEOUT_CYCLES));
        end
    end

    // Outputs are compared on the falling edge after busy drops.
    always @(negedge clk) begin : compare_results
        expect_t e;
        if (busy === 1'b1) begin
            busy_cycles = busy_cycles + 1;
        end else if (busy_prev) begin
            if (expected_q.size() == 0) begin
                report_failure("busy fell although no access was outstanding");
            end else begin
                e = expected_q.pop_front();
                check_word(instr, e.instr, "instr");
                check_word(read_data, e.read_data, "read_data");
                check_led(led, e.led, "led");
                if (busy_cycles != BUSY_CYCLES) begin
                    report_failure($sformatf(
                        "** Error at time %0t: busy lasted %0d cycles, expected %0d",
                        $time, busy_cycles, BUSY_CYCLES));
                end
            end
            busy_cycles = 0;
        end
        busy_prev = (busy === 1'b1);
    end

    initial begin
        int                     i;
        logic [`WORD_WIDTH-1:0] pc_r;
        logic [`WORD_WIDTH-1:0] addr_r;
        logic [31:0]            r;

        rst         = 1'b0;
        cpu_ready   = 1'b0;
        cpu         = '0;
        seed        = 32'h9a62;
        cycle_count = 0;
        busy_cycles = 0;
        busy_prev   = 1'b0;
        shadow_mem  = '{default: '0};
        shadow_led  = '0;

        repeat (2) @(posedge clk);
        #1;
        rst = 1'b1;

        check_word(instr, `NOP_INSTR, "instr after reset");
        check_word(read_data, '0, "read_data after reset");
        check_led(led, '0, "led after reset");
        check_flag(busy, 1'b0, "busy after reset");

        // DRAM round trip.
        drive_access(16'h0000, 16'h0000, 16'hC0DE, 1'b1);
        drive_access(16'h0010, 16'h0123, 16'hBEEF, 1'b1);
        drive_access(16'h0123, 16'h0123, 16'h0000, 1'b0);
        check_word(instr, 16'hBEEF, "instr fetched from written word");
        check_word(read_data, 16'hBEEF, "read_data of written word");
        drive_access(16'h0020, 16'h0123, 16'h5A5A, 1'b1);
        check_word(read_data, 16'hBEEF, "old word returned by write");
        drive_access(16'h0030, 16'hF7FF, 16'h1234, 1'b1);
        drive_access(16'hF7FF, 16'hF7FF, 16'h0000, 1'b0);

        // LED writes take bit 0 only.
        for (i = 0; i < `LED_COUNT; i++) begin
            drive_access(16'h0040 + 16'(i), `LED_FIRST + 16'(i),
                         16'hA500 | 16'((i % 3) != 0), 1'b1);
        end
        check_led(led, 10'h1B6, "led after first pass");
        drive_access(16'h004A, 16'hF801, 16'hFFFE, 1'b1);
        drive_access(16'h004B, 16'hF804, 16'h0000, 1'b1);
        check_led(led, 10'h1A4, "led after clearing");
        drive_access(16'h004C, 16'hF805, 16'h0000, 1'b0);
        check_word(read_data, 16'hC0DE, "LED read");
        drive_access(16'h0123, 16'h0000, 16'h0000, 1'b0);
        check_word(read_data, 16'hC0DE, "word 0 after LED writes");

        // Unmapped addresses.
        drive_access(16'h0050, 16'hF80A, 16'h7777, 1'b1);
        drive_access(16'h0051, 16'hFFFE, 16'h1111, 1'b1);
        drive_access(16'hF900, 16'hFABC, 16'h0000, 1'b0);
        check_word(instr, 16'hC0DE, "unmapped fetch");
        check_word(read_data, 16'hC0DE, "unmapped read");
        drive_access(16'h0052, 16'h0000, 16'h0000, 1'b0);
        check_word(read_data, 16'hC0DE, "word 0 after unmapped writes");

        // Start rule.
        drive_access(16'h0200, 16'h0300, 16'h4242, 1'b1);
        check_word(read_data, 16'h0000, "read_data before restart");
        hold_idle(20);
        cpu_ready = 1'b0;
        hold_idle(20);
        launch_access();
        check_word(read_data, 16'h4242, "read_data after restart");

        for (i = 0; i < RANDOM_ACCESSES; i++) begin
            pc_r   = random_addr();
            addr_r = random_addr();
            r      = $random(seed);
            drive_access(pc_r, addr_r, r[15:0], r[16]);
        end

        @(negedge clk);
        #1;
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire
